// File: common/game_macros.svh
// screen, sprite and jump geometry for the player controller.
// set-2 scan codes of the game keys and reset tick periods.
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// screen and sprite, in pixels.
`define HOR_PIXELS 1024
`define SPRITE_W 48
`define FLOOR_Y 700
`define JUMP_H 58
`define START_X 100

// set-2 scan codes.
`define SCAN_LEFT 8'h1C
`define SCAN_RIGHT 8'h23
`define SCAN_JUMP 8'h29
`define SCAN_BREAK 8'hF0

// tick periods in clock cycles.
`define STEP_PERIOD_RST 250_000
`define JUMP_PERIOD_RST 1_400_000

`endif

// File: common/game_pkg.sv
// shared types of the player controller.
// coordinates, scan bytes, tick periods, velocity, movement states.
package game_pkg;

    // screen coordinate in pixels.
    typedef logic [11:0] coord_t;

    // keyboard scan byte.
    typedef logic [7:0] scan_t;

    // tick period in clock cycles, holds the 1.4M reset value.
    typedef logic [20:0] period_t;

    // vertical speed in pixels per jump tick.
    typedef logic [11:0] velocity_t;

    typedef enum logic [2:0] {
        IDLE,
        GO_LEFT,
        GO_RIGHT,
        JUMP,
        FALL
    } move_state_t;

endpackage

// File: hw/key_decoder.sv
// set-2 scan byte decoder with break prefix tracking.
// keeps hold flags for the left, right and jump keys.
`timescale 1ns/1ps
`include "game_macros.svh"

module key_decoder (
    input  logic            clk,
    input  logic            rst,
    input  logic            scan_valid,
    input  game_pkg::scan_t scan_byte,
    output logic            left_held,
    output logic            right_held,
    output logic            jump_held
);

    logic break_armed;
    logic is_break;

    assign is_break = (scan_byte == `SCAN_BREAK);

    always_ff @(posedge clk) begin
        if (rst) begin
            break_armed <= 1'b0;
            left_held   <= 1'b0;
            right_held  <= 1'b0;
            jump_held   <= 1'b0;
        end else if (scan_valid) begin
            if (is_break) begin
                break_armed <= 1'b1;
            end else begin
                break_armed <= 1'b0; // any other byte consumes the prefix.
                case (scan_byte)
                    `SCAN_LEFT: begin
                        left_held <= !break_armed;
                    end
                    `SCAN_RIGHT: begin
                        right_held <= !break_armed;
                    end
                    `SCAN_JUMP: begin
                        jump_held <= !break_armed;
                    end
                    default: begin
                        // unrelated key leaves the flags.
                    end
                endcase
            end
        end
    end

    // an armed break is consumed by the next non-prefix byte.
    a_break_consumed: assert property (
        @(posedge clk) disable iff (rst)
        break_armed && scan_valid && !is_break |=> !break_armed
    ) else $error("break prefix not consumed by following byte.");

endmodule

// File: hw/move_config.sv
// tick period register block for the movement logic.
// strobe write, combinational read-back.
`timescale 1ns/1ps
`include "game_macros.svh"

module move_config (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_wr,
    input  logic              cfg_addr,
    input  game_pkg::period_t cfg_wdata,
    output game_pkg::period_t cfg_rdata,
    output game_pkg::period_t step_period,
    output game_pkg::period_t jump_period
);

    localparam game_pkg::period_t step_rst = game_pkg::period_t'(`STEP_PERIOD_RST);
    localparam game_pkg::period_t jump_rst = game_pkg::period_t'(`JUMP_PERIOD_RST);

    always_ff @(posedge clk) begin
        if (rst) begin
            step_period <= step_rst;
            jump_period <= jump_rst;
        end else if (cfg_wr) begin
            if (cfg_addr) begin
                jump_period <= cfg_wdata;
            end else begin
                step_period <= cfg_wdata;
            end
        end
    end

    // address 0 step, 1 jump.
    assign cfg_rdata = cfg_addr ? jump_period : step_period;

    // zero period would leave the tick counter stuck at terminal count.
    a_period_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        cfg_wr |=> (step_period != '0) && (jump_period != '0)
    ) else $error("tick period written as zero.");

endmodule

// File: movement/movement.sv
// player movement FSM driven by the key hold flags.
// clamped horizontal steps, accelerated jump and fall.
`timescale 1ns/1ps
`include "game_macros.svh"

module movement (
    input  logic              clk,
    input  logic              rst,
    input  logic              left_held,
    input  logic              right_held,
    input  logic              jump_held,
    input  game_pkg::period_t step_period,
    input  game_pkg::period_t jump_period,
    output game_pkg::coord_t  xpos,
    output game_pkg::coord_t  ypos
);

    localparam game_pkg::coord_t x_max   = game_pkg::coord_t'(`HOR_PIXELS - `SPRITE_W);
    localparam game_pkg::coord_t x_start = game_pkg::coord_t'(`START_X);
    localparam game_pkg::coord_t y_floor = game_pkg::coord_t'(`FLOOR_Y);
    localparam game_pkg::coord_t y_apex  = game_pkg::coord_t'(`FLOOR_Y - `JUMP_H);

    game_pkg::move_state_t state;
    game_pkg::move_state_t state_nxt;
    game_pkg::period_t     tick_cnt;
    game_pkg::period_t     tick_cnt_nxt;
    game_pkg::period_t     tick_period;
    game_pkg::coord_t      xpos_nxt;
    game_pkg::coord_t      ypos_nxt;
    game_pkg::velocity_t   velocity;
    game_pkg::velocity_t   velocity_nxt;
    logic                  tick_done;

    // horizontal states use the step period, vertical ones the jump period.
    assign tick_period = ((state == game_pkg::GO_LEFT) || (state == game_pkg::GO_RIGHT)) ?
                         step_period : jump_period;
    assign tick_done   = (tick_cnt == tick_period);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= game_pkg::IDLE;
            tick_cnt <= '0;
            xpos     <= x_start;
            ypos     <= y_floor;
            velocity <= '0;
        end else begin
            state    <= state_nxt;
            tick_cnt <= tick_cnt_nxt;
            xpos     <= xpos_nxt;
            ypos     <= ypos_nxt;
            velocity <= velocity_nxt;
        end
    end

    always_comb begin
        state_nxt    = state;
        tick_cnt_nxt = tick_done ? '0 : tick_cnt + 1'b1;
        xpos_nxt     = xpos;
        ypos_nxt     = ypos;
        velocity_nxt = velocity;

        case (state)
            game_pkg::IDLE: begin
                tick_cnt_nxt = '0;
                velocity_nxt = '0;
                // left wins over right, right over jump.
                if (left_held) begin
                    state_nxt = game_pkg::GO_LEFT;
                end else if (right_held) begin
                    state_nxt = game_pkg::GO_RIGHT;
                end else if (jump_held) begin
                    state_nxt = game_pkg::JUMP;
                end
            end

            game_pkg::GO_LEFT: begin
                if (tick_done) begin
                    state_nxt = game_pkg::IDLE;
                    if (xpos != '0) begin
                        xpos_nxt = xpos - 1'b1;
                    end
                end
            end

            game_pkg::GO_RIGHT: begin
                if (tick_done) begin
                    state_nxt = game_pkg::IDLE;
                    if (xpos < x_max) begin
                        xpos_nxt = xpos + 1'b1;
                    end
                end
            end

            game_pkg::JUMP: begin
                if (tick_done) begin
                    if (velocity >= ypos - y_apex) begin
                        ypos_nxt     = y_apex; // apex reached.
                        velocity_nxt = '0;
                        state_nxt    = game_pkg::FALL;
                    end else begin
                        ypos_nxt     = ypos - velocity;
                        velocity_nxt = velocity + 1'b1;
                    end
                end
            end

            game_pkg::FALL: begin
                if (tick_done) begin
                    if (velocity >= y_floor - ypos) begin
                        ypos_nxt  = y_floor; // landed.
                        state_nxt = game_pkg::IDLE;
                    end else begin
                        ypos_nxt     = ypos + velocity;
                        velocity_nxt = velocity + 1'b1;
                    end
                end
            end

            default: begin
                state_nxt = game_pkg::IDLE;
            end
        endcase
    end

    // sprite never leaves the screen horizontally.
    a_xpos_range: assert property (
        @(posedge clk) disable iff (rst)
        xpos <= x_max
    ) else $error("xpos beyond right screen edge.");

    // sprite stays between the apex and the floor.
    a_ypos_range: assert property (
        @(posedge clk) disable iff (rst)
        (ypos >= y_apex) && (ypos <= y_floor)
    ) else $error("ypos outside apex to floor range.");

endmodule

// File: hw/game_ctrl_top.sv
// player controller top level.
// key decoder, period registers and movement FSM.
`timescale 1ns/1ps

module game_ctrl_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              scan_valid,
    input  game_pkg::scan_t   scan_byte,
    input  logic              cfg_wr,
    input  logic              cfg_addr,
    input  game_pkg::period_t cfg_wdata,
    output game_pkg::period_t cfg_rdata,
    output game_pkg::coord_t  xpos,
    output game_pkg::coord_t  ypos
);

    logic              left_held;
    logic              right_held;
    logic              jump_held;
    game_pkg::period_t step_period;
    game_pkg::period_t jump_period;

    key_decoder key_decoder_inst (
        .clk        (clk),
        .rst        (rst),
        .scan_valid (scan_valid),
        .scan_byte  (scan_byte),
        .left_held  (left_held),
        .right_held (right_held),
        .jump_held  (jump_held)
    );

    move_config move_config_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .step_period (step_period),
        .jump_period (jump_period)
    );

    movement movement_inst (
        .clk         (clk),
        .rst         (rst),
        .left_held   (left_held),
        .right_held  (right_held),
        .jump_held   (jump_held),
        .step_period (step_period),
        .jump_period (jump_period),
        .xpos        (xpos),
        .ypos        (ypos)
    );

endmodule

// File: test/tb_game_ctrl.sv
// testbench for the player controller top level.
// stimulus table of period writes, scan bytes, waits and position checks.
`timescale 1ns/1ps
`include "game_macros.svh"

module tb_game_ctrl;

    localparam int OP_WR     = 0;  // write period a with b.
    localparam int OP_RD     = 1;  // read back period a, expect b.
    localparam int OP_KEY    = 2;  // send scan byte a.
    localparam int OP_WAIT   = 3;
    localparam int OP_X      = 4;  // xpos within a to b.
    localparam int OP_Y      = 5;
    localparam int OP_SAVEX  = 6;
    localparam int OP_SAMEX  = 7;
    localparam int OP_MINRST = 8;
    localparam int OP_MINY   = 9;
    localparam int OP_UNTILY = 10; // wait for ypos a, at most b cycles.

    localparam int STEP_P   = 3;
    localparam int JUMP_P   = 2;
    localparam int STEP_CYC = STEP_P + 2; // counter plus idle re-entry.
    localparam int MARGIN   = 200;
    localparam int X_MAX    = `HOR_PIXELS - `SPRITE_W;
    localparam int Y_APEX   = `FLOOR_Y - `JUMP_H;

    logic              clk;
    logic              rst;
    logic              scan_valid;
    game_pkg::scan_t   scan_byte;
    logic              cfg_wr;
    logic              cfg_addr;
    game_pkg::period_t cfg_wdata;
    game_pkg::period_t cfg_rdata;
    game_pkg::coord_t  xpos;
    game_pkg::coord_t  ypos;

    int tbl_op[$];
    int tbl_a[$];
    int tbl_b[$];
    int cycle_cnt = 0;
    int cycle_limit;
    int saved_x;
    int y_min;

    game_ctrl_top game_ctrl_top_inst (
        .clk        (clk),
        .rst        (rst),
        .scan_valid (scan_valid),
        .scan_byte  (scan_byte),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .xpos       (xpos),
        .ypos       (ypos)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic fail_check(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic add_row(input int op, input int a, input int b);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
    endtask

    // one cycle, sampled at the falling edge.
    task automatic next_cycle();
        @(negedge clk);
        if (int'(ypos) < y_min) begin
            y_min = int'(ypos);
        end
    endtask

    task automatic release_key(input int code);
        add_row(OP_KEY, `SCAN_BREAK, 0);
        add_row(OP_KEY, code, 0);
    endtask

    task automatic build_table();
        // reset state and period registers.
        add_row(OP_X, `START_X, `START_X);
        add_row(OP_Y, `FLOOR_Y, 0);
        add_row(OP_RD, 0, `STEP_PERIOD_RST);
        add_row(OP_RD, 1, `JUMP_PERIOD_RST);
        add_row(OP_WR, 0, STEP_P);
        add_row(OP_WR, 1, JUMP_P);
        add_row(OP_RD, 0, STEP_P);
        add_row(OP_RD, 1, JUMP_P);
        // ten steps left, one may be in flight at release.
        add_row(OP_KEY, `SCAN_LEFT, 0);
        add_row(OP_WAIT, 10 * STEP_CYC, 0);
        release_key(`SCAN_LEFT);
        add_row(OP_WAIT, 2 * STEP_CYC, 0);
        add_row(OP_X, `START_X - 11, `START_X - 9);
        add_row(OP_SAVEX, 0, 0);
        add_row(OP_WAIT, 20, 0);
        add_row(OP_SAMEX, 0, 0);
        // left edge clamp.
        add_row(OP_KEY, `SCAN_LEFT, 0);
        add_row(OP_WAIT, (`START_X + 10) * STEP_CYC, 0);
        add_row(OP_X, 0, 0);
        add_row(OP_WAIT, 20, 0);
        add_row(OP_X, 0, 0);
        release_key(`SCAN_LEFT);
        add_row(OP_WAIT, 2 * STEP_CYC, 0);
        // right edge clamp.
        add_row(OP_KEY, `SCAN_RIGHT, 0);
        add_row(OP_WAIT, (X_MAX + 10) * STEP_CYC, 0);
        add_row(OP_X, X_MAX, X_MAX);
        add_row(OP_SAVEX, 0, 0);
        add_row(OP_WAIT, 20, 0);
        add_row(OP_SAMEX, 0, 0);
        release_key(`SCAN_RIGHT);
        add_row(OP_WAIT, 2 * STEP_CYC, 0);
        // jump up to the apex and back down.
        add_row(OP_MINRST, 0, 0);
        add_row(OP_KEY, `SCAN_JUMP, 0);
        release_key(`SCAN_JUMP);
        add_row(OP_WAIT, 20, 0);
        add_row(OP_UNTILY, `FLOOR_Y, 200);
        add_row(OP_MINY, Y_APEX, 0);
        add_row(OP_X, X_MAX, X_MAX);
        // unrelated key leaves the sprite alone.
        add_row(OP_KEY, 8'h1D, 0);
        release_key(8'h1D);
        add_row(OP_WAIT, 20, 0);
        add_row(OP_X, X_MAX, X_MAX);
        add_row(OP_Y, `FLOOR_Y, 0);
    endtask

    task automatic apply_row(input int i);
        int n;
        case (tbl_op[i])
            OP_WR: begin
                @(posedge clk);
                cfg_wr    <= 1'b1;
                cfg_addr  <= (tbl_a[i] != 0);
                cfg_wdata <= game_pkg::period_t'(tbl_b[i]);
                @(posedge clk);
                cfg_wr    <= 1'b0;
            end
            OP_RD: begin
                @(posedge clk);
                cfg_addr <= (tbl_a[i] != 0);
                @(negedge clk);
                assert (cfg_rdata == tbl_b[i]) else fail_check($sformatf(
                    "period %0d reads %0d, expected %0d", tbl_a[i], cfg_rdata, tbl_b[i]));
            end
            OP_KEY: begin
                @(posedge clk);
                scan_valid <= 1'b1;
                scan_byte  <= game_pkg::scan_t'(tbl_a[i]);
                @(posedge clk);
                scan_valid <= 1'b0;
            end
            OP_WAIT: begin
                repeat (tbl_a[i]) next_cycle();
            end
            OP_X: begin
                @(negedge clk);
                assert ((xpos >= tbl_a[i]) && (xpos <= tbl_b[i])) else fail_check($sformatf(
                    "xpos %0d, expected %0d to %0d", xpos, tbl_a[i], tbl_b[i]));
            end
            OP_Y: begin
                @(negedge clk);
                assert (ypos == tbl_a[i]) else fail_check($sformatf(
                    "ypos %0d, expected %0d", ypos, tbl_a[i]));
            end
            OP_SAVEX: begin
                @(negedge clk);
                saved_x = int'(xpos);
            end
            OP_SAMEX: begin
                @(negedge clk);
                assert (xpos == saved_x) else fail_check($sformatf(
                    "xpos moved to %0d after release, was %0d", xpos, saved_x));
            end
            OP_MINRST: begin
                y_min = 4095;
            end
            OP_MINY: begin
                assert (y_min == tbl_a[i]) else fail_check($sformatf(
                    "lowest ypos %0d, expected apex %0d", y_min, tbl_a[i]));
            end
            OP_UNTILY: begin
                n = 0;
                while ((ypos != tbl_a[i]) && (n < tbl_b[i])) begin
                    next_cycle();
                    n++;
                end
                assert (ypos == tbl_a[i]) else fail_check($sformatf(
                    "ypos %0d, not back at %0d within %0d cycles", ypos, tbl_a[i], tbl_b[i]));
            end
            default: begin
                $display("unknown table operation %0d in row %0d", tbl_op[i], i);
                $display("ERRORS FOUND");
                $fatal(1, "bad stimulus table");
            end
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        scan_valid = 1'b0;
        scan_byte  = '0;
        cfg_wr     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_wdata  = '0;
        saved_x    = 0;
        y_min      = 4095;
        build_table();
        cycle_limit = MARGIN;
        foreach (tbl_op[i]) begin
            if (tbl_op[i] == OP_WAIT) begin
                cycle_limit += tbl_a[i];
            end else if (tbl_op[i] == OP_UNTILY) begin
                cycle_limit += tbl_b[i];
            end
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        foreach (tbl_op[i]) begin
            apply_row(i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: build.f
+incdir+common
common/game_pkg.sv
hw/key_decoder.sv
hw/move_config.sv
movement/movement.sv
hw/game_ctrl_top.sv
test/tb_game_ctrl.sv
